// ==== hw/mul_pkg.sv ====
package mul_pkg;

	localparam int xlen = 64;       // Operand width.
	localparam int ext_w = 66;      // Two guard bits above the operand.
	localparam int pp_w = 132;      // Partial product width.
	localparam int pp_n = 33;       // Radix-4 digits over ext_w bits.
	localparam int col_cin_w = 31;  // Lateral carries between columns.

	// Bit 0 marks the multiplicand signed, bit 1 the multiplier.
	typedef enum logic [1:0] {
		mul_uu = 2'b00,
		mul_su = 2'b01,  // Signed multiplicand, unsigned multiplier.
		mul_us = 2'b10,  // Unsigned multiplicand, signed multiplier.
		mul_ss = 2'b11
	} mul_sign_e;

	typedef struct packed {
		mul_sign_e mode;
		logic mulw;  // Low word of each operand only.
		logic [xlen-1:0] multiplicand;
		logic [xlen-1:0] multiplier;
	} mul_req_t;

	// Stage 1 contents.
	typedef struct packed {
		logic [pp_n-1:0][pp_w-1:0] pp;
		logic [pp_n-1:0] neg;  // Pending +1 for each inverted product.
	} pp_stage_t;

	// Stage 2 contents.
	typedef struct packed {
		logic [pp_w-1:0] sum;
		logic [pp_w-2:0] carry;  // Weighted one column up.
		logic neg31;
		logic neg32;
	} csa_stage_t;

	typedef struct packed {
		logic [xlen-1:0] hi;
		logic [xlen-1:0] lo;
	} mul_res_t;

endpackage

// ==== hw/booth_pp_gen.sv ====
module booth_pp_gen
	import mul_pkg::*;
(
	input logic [2:0] window,
	input logic [pp_w-1:0] operand,
	output logic [pp_w-1:0] pp,
	output logic neg
);

	typedef enum logic [2:0] {
		sel_zero,
		sel_pos1,
		sel_pos2,
		sel_neg1,
		sel_neg2
	} booth_sel_e;

	booth_sel_e sel;

	// Window is {b[2i+1], b[2i], b[2i-1]}.
	always_comb begin
		case (window)
			3'b001, 3'b010: sel = sel_pos1;
			3'b011: sel = sel_pos2;
			3'b100: sel = sel_neg2;
			3'b101, 3'b110: sel = sel_neg1;
			default: sel = sel_zero;  // 000 and 111.
		endcase
	end

	// Negative picks are inverted and neg carries the missing +1.
	always_comb begin
		pp = '0;
		neg = 1'b0;
		case (sel)
			sel_pos1: pp = operand;
			sel_pos2: pp = operand << 1;
			sel_neg1: begin
				pp = ~operand;
				neg = 1'b1;
			end
			sel_neg2: begin
				pp = ~(operand << 1);
				neg = 1'b1;
			end
			default: pp = '0;
		endcase
	end

endmodule

// ==== hw/booth_pp_array.sv ====
module booth_pp_array
	import mul_pkg::*;
(
	input mul_req_t req,
	output pp_stage_t pps
);

	logic mcand_signed;
	logic mplier_signed;
	logic [ext_w-1:0] mcand_ext;
	logic [ext_w-1:0] mplier_ext;
	logic [ext_w:0] window_src;    // Implicit zero below bit 0.
	logic [pp_w-1:0] mplier_wide;
	wire [pp_n-1:0][pp_w-1:0] pp_vec;
	wire [pp_n-1:0] neg_vec;

	// Guard bits copy the sign only when the operand is signed.
	function automatic logic [ext_w-1:0] extend(
		input logic [xlen-1:0] val,
		input logic is_signed,
		input logic word
	);
		logic [xlen-1:0] low;

		if (word) begin
			low = {{(xlen-32){is_signed & val[31]}}, val[31:0]};
		end else begin
			low = val;
		end
		return {{(ext_w-xlen){is_signed & low[xlen-1]}}, low};
	endfunction

	assign mcand_signed = req.mode inside {mul_su, mul_ss};
	assign mplier_signed = req.mode inside {mul_us, mul_ss};

	assign mcand_ext = extend(req.multiplicand, mcand_signed, req.mulw);
	assign mplier_ext = extend(req.multiplier, mplier_signed, req.mulw);

	// The multiplicand is scanned in overlapping 3-bit windows.
	assign window_src = {mcand_ext, 1'b0};

	// Partial products are built at full product width.
	assign mplier_wide = {{(pp_w-ext_w){mplier_ext[ext_w-1]}}, mplier_ext};

	for (genvar i = 0; i < pp_n; i++) begin : g_pp
		logic [pp_w-1:0] operand;

		assign operand = mplier_wide << (2 * i);  // Weight 4^i.

		booth_pp_gen booth_pp_gen_inst (
			.window (window_src[2*i+2 -: 3]),
			.operand(operand),
			.pp     (pp_vec[i]),
			.neg    (neg_vec[i])
		);
	end

	assign pps = '{pp: pp_vec, neg: neg_vec};

endmodule

// ==== hw/wallace_column.sv ====
module wallace_column
	import mul_pkg::*;
(
	input logic [pp_n-1:0] bits,
	input logic [col_cin_w-1:0] cin,
	output logic [col_cin_w-1:0] cout,
	output logic carry,
	output logic sum
);

	// Inputs of each level with the carries from the column below.
	logic [21:0] l2_in;
	logic [14:0] l3_in;
	logic [9:0] l4_in;
	logic [6:0] l5_in;
	logic [4:0] l6_in;
	logic [3:0] l7_in;
	logic [2:0] l8_in;

	// Sums each level keeps in this column.
	logic [10:0] l1_s;
	logic [6:0] l2_s;
	logic [4:0] l3_s;
	logic [2:0] l4_s;
	logic [1:0] l5_s;
	logic [1:0] l6_s;
	logic l7_s;

	// Returns {carry, sum}.
	function automatic logic [1:0] fa(input logic a, input logic b, input logic c);
		return {(a & b) | (a & c) | (b & c), a ^ b ^ c};
	endfunction

	always_comb begin
		// 33 to 22.
		for (int k = 0; k < 11; k++) begin
			{cout[k], l1_s[k]} = fa(bits[3*k], bits[3*k+1], bits[3*k+2]);
		end
		l2_in = {cin[10:0], l1_s};

		// 22 to 15, one bit passes.
		for (int k = 0; k < 7; k++) begin
			{cout[11+k], l2_s[k]} = fa(l2_in[3*k], l2_in[3*k+1], l2_in[3*k+2]);
		end
		l3_in = {cin[17:11], l2_in[21], l2_s};

		// 15 to 10.
		for (int k = 0; k < 5; k++) begin
			{cout[18+k], l3_s[k]} = fa(l3_in[3*k], l3_in[3*k+1], l3_in[3*k+2]);
		end
		l4_in = {cin[22:18], l3_s};

		// 10 to 7.
		for (int k = 0; k < 3; k++) begin
			{cout[23+k], l4_s[k]} = fa(l4_in[3*k], l4_in[3*k+1], l4_in[3*k+2]);
		end
		l5_in = {cin[25:23], l4_in[9], l4_s};

		// 7 to 5.
		for (int k = 0; k < 2; k++) begin
			{cout[26+k], l5_s[k]} = fa(l5_in[3*k], l5_in[3*k+1], l5_in[3*k+2]);
		end
		l6_in = {cin[27:26], l5_in[6], l5_s};

		// 5 to 4. The second adder works as a half adder
		// so the column passes on its 31st carry.
		{cout[28], l6_s[0]} = fa(l6_in[0], l6_in[1], l6_in[2]);
		{cout[29], l6_s[1]} = fa(l6_in[3], l6_in[4], 1'b0);
		l7_in = {cin[29:28], l6_s};

		// 4 to 3.
		{cout[30], l7_s} = fa(l7_in[0], l7_in[1], l7_in[2]);
		l8_in = {cin[30], l7_in[3], l7_s};

		// 3 to 2, carry belongs to the next column up.
		{carry, sum} = fa(l8_in[0], l8_in[1], l8_in[2]);
	end

endmodule

// ==== hw/wallace_tree.sv ====
module wallace_tree
	import mul_pkg::*;
(
	input logic [pp_n-1:0][pp_w-1:0] pps,
	input logic [col_cin_w-1:0] neg_in,
	output logic [pp_w-1:0] sum,
	output logic [pp_w-2:0] carry
);

	wire [col_cin_w-1:0] lateral [pp_w];  // lateral[c] feeds column c.
	wire [pp_w-1:0] col_sum;
	wire [pp_w-2:0] col_carry;

	// Column 0 has no column below, so it takes the pending +1s.
	assign lateral[0] = neg_in;

	for (genvar c = 0; c < pp_w; c++) begin : g_col
		wire [pp_n-1:0] col_bits;

		// Bit c of every partial product.
		for (genvar k = 0; k < pp_n; k++) begin : g_bit
			assign col_bits[k] = pps[k][c];
		end

		if (c < pp_w - 1) begin : g_mid
			wallace_column wallace_column_inst (
				.bits (col_bits),
				.cin  (lateral[c]),
				.cout (lateral[c+1]),
				.carry(col_carry[c]),
				.sum  (col_sum[c])
			);
		end else begin : g_top
			// Anything carried out of here lies above the product.
			wallace_column wallace_column_inst (
				.bits (col_bits),
				.cin  (lateral[c]),
				.cout (),
				.carry(),
				.sum  (col_sum[c])
			);
		end
	end

	assign sum = col_sum;
	assign carry = col_carry;

endmodule

// ==== hw/booth_wallace_mul.sv ====
module booth_wallace_mul
	import mul_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic flush,      // Drops everything in flight.
	input logic mul_valid,
	input mul_req_t req,
	output logic out_valid,
	output mul_res_t res
);

	pp_stage_t pp_d;
	pp_stage_t pp_q;
	logic pp_valid;
	logic [pp_w-1:0] tree_sum;
	logic [pp_w-2:0] tree_carry;
	csa_stage_t csa_d;
	csa_stage_t csa_q;
	logic csa_valid;
	logic [pp_w-1:0] product;

	booth_pp_array booth_pp_array_inst (
		.req(req),
		.pps(pp_d)
	);

	// Stage 1 holds the Booth partial products.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pp_valid <= 1'b0;
			pp_q <= '0;
		end else if (flush) begin
			pp_valid <= 1'b0;
			pp_q <= '0;
		end else begin
			pp_valid <= mul_valid;
			if (mul_valid) begin
				pp_q <= pp_d;
			end
		end
	end

	wallace_tree wallace_tree_inst (
		.pps   (pp_q.pp),
		.neg_in(pp_q.neg[col_cin_w-1:0]),
		.sum   (tree_sum),
		.carry (tree_carry)
	);

	// The last two +1s skip the tree.
	assign csa_d = '{
		sum:   tree_sum,
		carry: tree_carry,
		neg31: pp_q.neg[pp_n-2],
		neg32: pp_q.neg[pp_n-1]
	};

	// Stage 2 holds the carry-save pair.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csa_valid <= 1'b0;
			csa_q <= '0;
		end else if (flush) begin
			csa_valid <= 1'b0;
			csa_q <= '0;
		end else begin
			csa_valid <= pp_valid;
			if (pp_valid) begin
				csa_q <= csa_d;
			end
		end
	end

	// neg31 fills the free bit 0 of the shifted carry vector.
	assign product = csa_q.sum + {csa_q.carry, csa_q.neg31} + pp_w'(csa_q.neg32);

	assign res = '{hi: product[2*xlen-1:xlen], lo: product[xlen-1:0]};
	assign out_valid = csa_valid;

endmodule

// ==== test/mul_ref.svh ====
`ifndef MUL_REF_SVH
`define MUL_REF_SVH

// Operand as a 128-bit value, word mode applied first.
function automatic logic [127:0] ref_extend(
	input logic [63:0] val,
	input logic is_signed,
	input logic word
);
	logic [63:0] low;

	if (word) begin
		low = {{32{is_signed & val[31]}}, val[31:0]};
	end else begin
		low = val;
	end
	return {{64{is_signed & low[63]}}, low};
endfunction

// Full product, truncated to 128 bits.
function automatic logic [127:0] ref_product(input mul_req_t r);
	logic [127:0] a;
	logic [127:0] b;

	a = ref_extend(r.multiplicand, r.mode inside {mul_su, mul_ss}, r.mulw);
	b = ref_extend(r.multiplier, r.mode inside {mul_us, mul_ss}, r.mulw);
	return a * b;
endfunction

// Expected result in the shape the DUT returns it.
function automatic mul_res_t ref_result(input mul_req_t r);
	logic [127:0] p;
	mul_res_t res;

	p = ref_product(r);
	res.hi = p[127:64];
	res.lo = p[63:0];
	return res;
endfunction

`endif

// ==== test/tb_booth_wallace_mul.sv ====
module tb_booth_wallace_mul
	import mul_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	`include "mul_ref.svh"

	localparam int reset_cycles = 16;
	localparam int drain_cycles = 4;  // Two stages plus the idle edge.
	localparam int n_tests = 6;
	localparam int n_unsigned = 15;
	localparam int n_signed = 30;
	localparam int n_word = 28;
	localparam int n_pipe = 40;
	localparam int n_flush = 3;
	localparam int idle_cycles = 8;  // After reset and after the flush.
	localparam int timeout_cycles = reset_cycles + n_unsigned + n_signed + n_word
		+ n_pipe + n_flush + idle_cycles + n_tests * drain_cycles + 50;

	logic clk;
	logic rst_n;
	logic flush;
	logic mul_valid;
	mul_req_t req;
	logic out_valid;
	mul_res_t res;

	int cycle = 0;
	mul_res_t exp_q[$];  // Expected results in issue order.
	string name_q[$];
	int due_q[$];        // Cycle in which out_valid must show.

	booth_wallace_mul booth_wallace_mul_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.flush    (flush),
		.mul_valid(mul_valid),
		.req      (req),
		.out_valid(out_valid),
		.res      (res)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Test failures found");
			$fatal(1);
		end
	end

	function automatic logic [63:0] rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic mul_req_t make_req(
		input mul_sign_e mode,
		input logic mulw,
		input logic [63:0] a,
		input logic [63:0] b
	);
		return '{mode: mode, mulw: mulw, multiplicand: a, multiplier: b};
	endfunction

	// One request on the next edge and its expected result.
	task automatic issue(input string name, input mul_req_t r);
		@(posedge clk);
		req <= r;
		mul_valid <= 1'b1;
		exp_q.push_back(ref_result(r));
		name_q.push_back(name);
		due_q.push_back(cycle + 3);  // cycle still holds the previous count.
	endtask

	task automatic drop_pending(input int n);
		repeat (n) begin
			void'(exp_q.pop_back());
			void'(name_q.pop_back());
			void'(due_q.pop_back());
		end
	endtask

	task automatic go_idle();
		@(posedge clk);
		mul_valid <= 1'b0;
		flush <= 1'b0;
	endtask

	task automatic wait_drain();
		go_idle();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic unsigned_products();
		issue("unsigned", make_req(mul_uu, 1'b0, '1, '1));
		issue("unsigned", make_req(mul_uu, 1'b0, '1, 64'd1));
		issue("unsigned", make_req(mul_uu, 1'b0, 64'd0, '1));
		issue("unsigned", make_req(mul_uu, 1'b0, 64'h8000_0000_0000_0000, 64'd2));
		issue("unsigned", make_req(mul_uu, 1'b0, 64'h1_0000_0000, 64'h1_0000_0000));
		repeat (n_unsigned - 5) begin
			issue("unsigned", make_req(mul_uu, 1'b0, rand64(), rand64()));
		end
		wait_drain();
	endtask

	task automatic signed_corners();
		mul_sign_e mode;
		string name;
		logic [63:0] neg_val;

		for (int m = 1; m < 4; m++) begin
			mode = mul_sign_e'(2'(m));
			name = $sformatf("signed %s", mode.name());
			issue(name, make_req(mode, 1'b0,
				64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000));
			issue(name, make_req(mode, 1'b0, 64'h8000_0000_0000_0000, '1));
			issue(name, make_req(mode, 1'b0, '1, '1));
			issue(name, make_req(mode, 1'b0, '1, 64'h7fff_ffff_ffff_ffff));
			repeat (3) begin
				neg_val = rand64() | 64'h8000_0000_0000_0000;  // Negative when signed.
				issue(name, make_req(mode, 1'b0, neg_val, rand64()));
				issue(name, make_req(mode, 1'b0, rand64(), neg_val));
			end
		end
		wait_drain();
	endtask

	// Upper halves are random and must not matter.
	task automatic word_products();
		mul_sign_e mode;
		string name;

		for (int m = 0; m < 4; m++) begin
			mode = mul_sign_e'(2'(m));
			name = $sformatf("word %s", mode.name());
			issue(name, make_req(mode, 1'b1,
				{$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff}));
			issue(name, make_req(mode, 1'b1,
				{$urandom, 32'h7fff_ffff}, {$urandom, 32'h8000_0000}));
			issue(name, make_req(mode, 1'b1,
				{$urandom, 32'hffff_ffff}, {$urandom, 32'hffff_ffff}));
			repeat (4) begin
				issue(name, make_req(mode, 1'b1, rand64(), rand64()));
			end
		end
		wait_drain();
	endtask

	task automatic back_to_back();
		logic [1:0] mode_bits;
		logic mulw;

		repeat (n_pipe) begin
			mode_bits = 2'($urandom_range(0, 3));
			mulw = 1'($urandom);
			issue("pipeline", make_req(mul_sign_e'(mode_bits), mulw, rand64(), rand64()));
		end
		wait_drain();
	endtask

	// First request sits in stage 1 and the second meets the flush.
	// The last request drains at the end of the run.
	task automatic flush_in_flight();
		issue("flush", make_req(mul_ss, 1'b0, rand64(), rand64()));
		issue("flush", make_req(mul_uu, 1'b0, rand64(), rand64()));
		flush <= 1'b1;
		drop_pending(2);
		go_idle();
		repeat (4) @(posedge clk);  // Nothing may come out here.
		issue("flush", make_req(mul_us, 1'b0, rand64(), rand64()));
	endtask

	always @(negedge clk) begin : check_results
		mul_res_t exp_res;
		string name;
		int due;

		if (!rst_n) begin
			assert (!out_valid) else begin
				$display("CHECK FAILED reset: expected out_valid 0, actual %b", out_valid);
				$display("Test failures found");
				$fatal(1);
			end
		end else if (out_valid) begin
			assert (exp_q.size() != 0) else begin
				$display("out_valid went high in cycle %0d with no request outstanding", cycle);
				$display("Test failures found");
				$fatal(1);
			end
			exp_res = exp_q.pop_front();
			name = name_q.pop_front();
			due = due_q.pop_front();
			assert (cycle == due) else begin
				$display("CHECK FAILED %s: expected result in cycle %0d, actual cycle %0d",
					name, due, cycle);
				$display("Test failures found");
				$fatal(1);
			end
			assert (res == exp_res) else begin
				$display("CHECK FAILED %s: expected %h_%h, actual %h_%h",
					name, exp_res.hi, exp_res.lo, res.hi, res.lo);
				$display("Test failures found");
				$fatal(1);
			end
		end
	end

	initial begin
		void'($urandom(32'hdf179a04));
		rst_n = 1'b0;
		flush = 1'b0;
		mul_valid = 1'b0;
		req = '0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);  // Idle with out_valid low.
		unsigned_products();
		signed_corners();
		word_products();
		back_to_back();
		flush_in_flight();
		go_idle();
		repeat (drain_cycles) @(posedge clk);
		if (exp_q.size() == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("%0d results never arrived", exp_q.size());
			$display("Test failures found");
			$fatal(1);
		end
	end

endmodule

// ==== booth_wallace_mul.f ====
+incdir+test
hw/mul_pkg.sv
hw/booth_pp_gen.sv
hw/booth_pp_array.sv
hw/wallace_column.sv
hw/wallace_tree.sv
hw/booth_wallace_mul.sv
test/tb_booth_wallace_mul.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --timing --assert --timescale 1ns/1ps
TOP ?= tb_booth_wallace_mul
FILELIST ?= booth_wallace_mul.f
OBJ_DIR ?= obj_dir
PASS_MSG ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Build, run, and decide pass or fail from the simulator output.
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
